/* hw/scroll_pkg.sv */
// ####################
// shared widths, video geometry and
// sequencer states for the scroll layers
// ####################
package scroll_pkg;

    // layer pixel, palette in [8:4] and color in [3:0]
    typedef logic [8:0] pxl_t;
    localparam pxl_t PXL_BLANK = 9'h1ff;   // outside window and after reset

    typedef logic [8:0] hcnt_t;    // hdump
    typedef logic [8:0] vcnt_t;    // vrender, vdump
    typedef logic [15:0] scroll_t;

    // {layer[1:0], tile row[3:0], tile column[5:0]}
    typedef logic [11:0] tmap_addr_t;
    // {palette[4:0], tile code[10:0]}
    typedef logic [15:0] tmap_data_t;

    // {layer[1:0], code[10:0], row in tile[4:0], word in row[1:0]}
    typedef logic [19:0] rom_addr_t;
    typedef logic [31:0] rom_data_t;   // eight nibbles, pixel 0 at [3:0]

    typedef logic [1:0] layer_t;   // 0..2 for scroll 1..3

    localparam int ACTIVE_W = 128;   // visible pixels per line
    typedef logic [6:0] buf_addr_t;

    // log2 of the tile size, 8x8, 16x16 and 32x32
    localparam logic [2:0][2:0] TILE_SHIFT = {3'd5, 3'd4, 3'd3};

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_DONE
    } seq_state_t;

endpackage

/* hw/scroll_sequencer.sv */
// ####################
// line start detection and
// per-layer render sequencing
// ####################
`timescale 1ns/100ps

module scroll_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                HB,
    input  scroll_pkg::vcnt_t   vrender,
    input  scroll_pkg::scroll_t hpos1,
    input  scroll_pkg::scroll_t vpos1,
    input  scroll_pkg::scroll_t hpos2,
    input  scroll_pkg::scroll_t vpos2,
    input  scroll_pkg::scroll_t hpos3,
    input  scroll_pkg::scroll_t vpos3,
    input  logic                layer_ack,
    output logic                line_start,
    output logic                layer_req,
    output scroll_pkg::layer_t  layer,
    output scroll_pkg::scroll_t lay_hpos,
    output scroll_pkg::scroll_t lay_vpos,
    output scroll_pkg::vcnt_t   line_v
);

    logic                   last_hb;
    scroll_pkg::seq_state_t st;

    // falling edge of HB, first clock of the active line
    assign line_start = last_hb && !HB;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_hb   <= 1'b0;
            st        <= scroll_pkg::IDLE;
            layer_req <= 1'b0;
            layer     <= '0;
            lay_hpos  <= '0;
            lay_vpos  <= '0;
            line_v    <= '0;
        end else begin
            last_hb <= HB;
            if (line_start) begin
                // restart at layer 0 even if the last line is unfinished
                line_v    <= vrender;
                layer     <= 2'd0;
                lay_hpos  <= hpos1;
                lay_vpos  <= vpos1;
                layer_req <= 1'b0;
                st        <= scroll_pkg::REQ;
            end else begin
                case (st)
                    scroll_pkg::REQ: begin
                        // previous ack must be gone first
                        if (!layer_ack) begin
                            layer_req <= 1'b1;
                            st        <= scroll_pkg::WAIT_DONE;
                        end
                    end
                    scroll_pkg::WAIT_DONE: begin
                        if (layer_ack) begin
                            layer_req <= 1'b0;
                            if (layer == 2'd2) begin
                                st <= scroll_pkg::IDLE;   // line complete
                            end else begin
                                layer <= layer + 2'd1;
                                st    <= scroll_pkg::REQ;
                                if (layer == 2'd0) begin
                                    lay_hpos <= hpos2;
                                    lay_vpos <= vpos2;
                                end else begin
                                    lay_hpos <= hpos3;
                                    lay_vpos <= vpos3;
                                end
                            end
                        end
                    end
                    default: begin
                        layer_req <= 1'b0;   // idle until next line
                    end
                endcase
            end
        end
    end

endmodule

/* hw/tile_fetcher.sv */
// ####################
// tile fetcher for one layer line
// tilemap read, ROM handshake, pixel writes
// ####################
`timescale 1ns/100ps

module tile_fetcher (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   layer_req,
    input  scroll_pkg::layer_t     layer,
    input  scroll_pkg::scroll_t    lay_hpos,
    input  scroll_pkg::scroll_t    lay_vpos,
    input  scroll_pkg::vcnt_t      line_v,
    input  logic                   line_start,
    input  scroll_pkg::tmap_data_t tile_data,
    input  logic                   rom_ack,
    input  scroll_pkg::rom_data_t  rom_data,
    output logic                   layer_ack,
    output scroll_pkg::tmap_addr_t tile_addr,
    output logic                   rom_req,
    output scroll_pkg::rom_addr_t  rom_addr,
    output logic                   buf_wr,
    output scroll_pkg::layer_t     buf_layer,
    output scroll_pkg::buf_addr_t  buf_addr,
    output scroll_pkg::pxl_t       buf_data
);

    typedef enum logic [2:0] {
        F_IDLE, F_TILE, F_CODE, F_REQ, F_ROM, F_HOLD, F_DONE, F_ACK
    } fetch_state_t;

    fetch_state_t          st;
    logic                  stop;
    scroll_pkg::scroll_t   f_x;      // x of the word being fetched
    logic [7:0]            f_h;      // its first screen pixel
    scroll_pkg::scroll_t   line_y, x_tile, y_tile, x_next;
    logic [7:0]            h_next;
    logic [3:0]            step;
    logic [2:0]            sh;
    logic [4:0]            tmask, x_in, y_in;
    logic [4:0]            f_pal, w_pal;
    logic [10:0]           f_code;
    scroll_pkg::rom_data_t f_word, w_word;
    logic                  w_busy;
    logic [2:0]            w_idx;    // nibble being written
    scroll_pkg::buf_addr_t w_pos;

    assign stop   = line_start;   // next line began, drop this one
    assign line_y = lay_vpos + scroll_pkg::scroll_t'(line_v);
    assign sh     = scroll_pkg::TILE_SHIFT[layer];
    assign tmask  = 5'((6'd1 << sh) - 6'd1);   // tile size minus one

    assign x_tile = f_x >> sh;
    assign y_tile = line_y >> sh;
    assign x_in   = f_x[4:0] & tmask;
    assign y_in   = line_y[4:0] & tmask;

    assign tile_addr = {layer, y_tile[3:0], x_tile[5:0]};

    // pixels left in the current word, only the first one can be partial
    assign step   = 4'd8 - {1'b0, f_x[2:0]};
    assign x_next = f_x + scroll_pkg::scroll_t'(step);
    assign h_next = f_h + 8'(step);

    assign buf_wr    = w_busy;
    assign buf_layer = layer;
    assign buf_addr  = w_pos;
    assign buf_data  = {w_pal, w_word[{w_idx, 2'b00} +: 4]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= F_IDLE;
            layer_ack <= 1'b0;
            rom_req   <= 1'b0;
            f_x       <= '0;
            f_h       <= '0;
            w_busy    <= 1'b0;
            w_idx     <= '0;
            w_pos     <= '0;
        end else begin
            if (rom_req && rom_ack) rom_req <= 1'b0;   // also finishes an aborted read
            if (w_busy) begin
                w_idx <= w_idx + 3'd1;
                w_pos <= w_pos + 7'd1;
                if (w_idx == 3'd7 || w_pos == scroll_pkg::buf_addr_t'(scroll_pkg::ACTIVE_W - 1))
                    w_busy <= 1'b0;
            end
            if (stop) begin
                st        <= F_IDLE;
                layer_ack <= 1'b0;
                w_busy    <= 1'b0;
            end else begin
                case (st)
                    F_IDLE: begin
                        if (layer_req) begin
                            f_x <= lay_hpos;
                            f_h <= '0;
                            st  <= F_TILE;
                        end
                    end
                    F_TILE: st <= F_CODE;   // tilemap RAM latency
                    F_CODE: st <= F_REQ;
                    F_REQ: begin
                        if (!rom_req && !rom_ack) begin
                            rom_req <= 1'b1;
                            st      <= F_ROM;
                        end
                    end
                    F_ROM:  if (rom_ack) st <= F_HOLD;
                    F_HOLD: begin
                        // hand the word over, next tile fetch overlaps the writes
                        if (!w_busy) begin
                            w_busy <= 1'b1;
                            w_idx  <= f_x[2:0];
                            w_pos  <= f_h[6:0];
                            f_x    <= x_next;
                            f_h    <= h_next;
                            st     <= (h_next >= 8'(scroll_pkg::ACTIVE_W)) ? F_DONE : F_TILE;
                        end
                    end
                    F_DONE: begin
                        if (!w_busy) begin
                            layer_ack <= 1'b1;
                            st        <= F_ACK;
                        end
                    end
                    F_ACK: begin
                        if (!layer_req) begin
                            layer_ack <= 1'b0;
                            st        <= F_IDLE;
                        end
                    end
                    default: st <= F_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st == F_CODE) begin
            f_pal  <= tile_data[15:11];
            f_code <= tile_data[10:0];
        end
        if (st == F_REQ && !rom_req && !rom_ack)
            rom_addr <= {layer, f_code, y_in, x_in[4:3]};
        if (st == F_ROM && rom_ack) f_word <= rom_data;
        if (st == F_HOLD && !w_busy) begin
            w_word <= f_word;
            w_pal  <= f_pal;
        end
    end

endmodule

/* hw/line_output.sv */
// ####################
// double-buffered line stores and
// windowed pixel outputs
// ####################
`timescale 1ns/100ps

module line_output (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  scroll_pkg::hcnt_t     hdump,
    input  logic                  line_start,
    input  logic                  buf_wr,
    input  scroll_pkg::layer_t    buf_layer,
    input  scroll_pkg::buf_addr_t buf_addr,
    input  scroll_pkg::pxl_t      buf_data,
    output scroll_pkg::pxl_t      scr1_pxl,
    output scroll_pkg::pxl_t      scr2_pxl,
    output scroll_pkg::pxl_t      scr3_pxl
);

    // two halves of ACTIVE_W pixels each, half select in the msb
    scroll_pkg::pxl_t line1 [0:255];
    scroll_pkg::pxl_t line2 [0:255];
    scroll_pkg::pxl_t line3 [0:255];

    logic             wr_half;
    logic             wr_en;
    logic [7:0]       wr_addr, rd_addr;
    logic             active;
    scroll_pkg::pxl_t rd1, rd2, rd3;

    assign wr_addr = {wr_half, buf_addr};
    assign rd_addr = {~wr_half, hdump[6:0]};   // display the other half
    assign active  = hdump < scroll_pkg::hcnt_t'(scroll_pkg::ACTIVE_W);

    // a late write of an abandoned line must not land in the half now shown
    assign wr_en = buf_wr && !line_start;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_half <= 1'b0;
        end else if (line_start) begin
            wr_half <= ~wr_half;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (buf_layer)
                2'd0:    line1[wr_addr] <= buf_data;
                2'd1:    line2[wr_addr] <= buf_data;
                2'd2:    line3[wr_addr] <= buf_data;
                default: ;
            endcase
        end
    end

    assign rd1 = line1[rd_addr];
    assign rd2 = line2[rd_addr];
    assign rd3 = line3[rd_addr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scr1_pxl <= scroll_pkg::PXL_BLANK;
            scr2_pxl <= scroll_pkg::PXL_BLANK;
            scr3_pxl <= scroll_pkg::PXL_BLANK;
        end else if (pxl_cen) begin
            if (active) begin
                scr1_pxl <= rd1;
                scr2_pxl <= rd2;
                scr3_pxl <= rd3;
            end else begin
                scr1_pxl <= scroll_pkg::PXL_BLANK;
                scr2_pxl <= scroll_pkg::PXL_BLANK;
                scr3_pxl <= scroll_pkg::PXL_BLANK;
            end
        end
    end

endmodule

/* hw/scroll_top.sv */
// ####################
// scroll layer renderer top
// ####################
`timescale 1ns/100ps

module scroll_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  logic                   HB,
    input  scroll_pkg::hcnt_t      hdump,
    input  scroll_pkg::vcnt_t      vrender,   // one line ahead of vdump
    input  scroll_pkg::vcnt_t      vdump,
    input  scroll_pkg::scroll_t    hpos1,
    input  scroll_pkg::scroll_t    vpos1,
    input  scroll_pkg::scroll_t    hpos2,
    input  scroll_pkg::scroll_t    vpos2,
    input  scroll_pkg::scroll_t    hpos3,
    input  scroll_pkg::scroll_t    vpos3,
    output scroll_pkg::tmap_addr_t tile_addr,
    input  scroll_pkg::tmap_data_t tile_data,
    output logic                   rom_req,
    output scroll_pkg::rom_addr_t  rom_addr,
    input  logic                   rom_ack,
    input  scroll_pkg::rom_data_t  rom_data,
    output scroll_pkg::pxl_t       scr1_pxl,
    output scroll_pkg::pxl_t       scr2_pxl,
    output scroll_pkg::pxl_t       scr3_pxl
);

    logic                  line_start;
    logic                  layer_req, layer_ack;
    scroll_pkg::layer_t    layer;
    scroll_pkg::scroll_t   lay_hpos, lay_vpos;
    scroll_pkg::vcnt_t     line_v;
    logic                  buf_wr;
    scroll_pkg::layer_t    buf_layer;
    scroll_pkg::buf_addr_t buf_addr;
    scroll_pkg::pxl_t      buf_data;

    scroll_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .HB         (HB),
        .vrender    (vrender),
        .hpos1      (hpos1),
        .vpos1      (vpos1),
        .hpos2      (hpos2),
        .vpos2      (vpos2),
        .hpos3      (hpos3),
        .vpos3      (vpos3),
        .layer_ack  (layer_ack),
        .line_start (line_start),
        .layer_req  (layer_req),
        .layer      (layer),
        .lay_hpos   (lay_hpos),
        .lay_vpos   (lay_vpos),
        .line_v     (line_v)
    );

    tile_fetcher u_fetcher (
        .clk        (clk),
        .rst        (rst),
        .layer_req  (layer_req),
        .layer      (layer),
        .lay_hpos   (lay_hpos),
        .lay_vpos   (lay_vpos),
        .line_v     (line_v),
        .line_start (line_start),   // stop
        .tile_data  (tile_data),
        .rom_ack    (rom_ack),
        .rom_data   (rom_data),
        .layer_ack  (layer_ack),
        .tile_addr  (tile_addr),
        .rom_req    (rom_req),
        .rom_addr   (rom_addr),
        .buf_wr     (buf_wr),
        .buf_layer  (buf_layer),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data)
    );

    line_output u_output (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .hdump      (hdump),
        .line_start (line_start),
        .buf_wr     (buf_wr),
        .buf_layer  (buf_layer),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data),
        .scr1_pxl   (scr1_pxl),
        .scr2_pxl   (scr2_pxl),
        .scr3_pxl   (scr3_pxl)
    );

endmodule

/* test/scroll_sva.sv */
// ####################
// handshake and reset assertions
// bound to the tile fetcher
// ####################
`timescale 1ns/100ps

module scroll_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  rom_req,
    input logic                  rom_ack,
    input scroll_pkg::rom_addr_t rom_addr,
    input logic                  layer_req,
    input logic                  layer_ack,
    input logic                  line_start,
    input logic                  buf_wr
);

    // address must not move during a ROM read
    assert property (@(posedge clk) disable iff (rst)
        rom_req && $past(rom_req) |-> rom_addr == $past(rom_addr))
        else $error("rom_addr changed while rom_req was high");

    assert property (@(posedge clk) disable iff (rst)
        $rose(rom_req) |-> !$past(rom_ack))
        else $error("rom_req rose while rom_ack was high");

    // only an ack or a new line may end a layer request
    assert property (@(posedge clk) disable iff (rst)
        $fell(layer_req) |-> $past(layer_ack) || $past(line_start))
        else $error("layer_req dropped before layer_ack");

    assert property (@(posedge clk)
        rst && $past(rst) |-> !rom_req && !layer_ack && !buf_wr)
        else $error("fetcher outputs active during reset");

endmodule

bind tile_fetcher scroll_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .rom_req    (rom_req),
    .rom_ack    (rom_ack),
    .rom_addr   (rom_addr),
    .layer_req  (layer_req),
    .layer_ack  (layer_ack),
    .line_start (line_start),
    .buf_wr     (buf_wr)
);

/* test/scroll_checker.sv */
// ####################
// output checker with a reference
// model of the three scroll layers
// ####################
`timescale 1ns/100ps

module scroll_checker (
    input logic              clk,
    input logic              rst,
    input logic              pxl_cen,
    input logic              line_start,
    input logic              rom_req,
    input scroll_pkg::hcnt_t hdump,
    input scroll_pkg::pxl_t  scr1_pxl,
    input scroll_pkg::pxl_t  scr2_pxl,
    input scroll_pkg::pxl_t  scr3_pxl
);

    int line_count = 0;
    int pix_count = 0;
    int blank_count = 0;
    int err_count = 0;
    int base_pix = 0;
    int base_blank = 0;
    int base_err = 0;

    logic                started = 1'b0;
    logic                rst_q = 1'b0;       // reset seen on an earlier edge
    logic                render_ok = 1'b0;   // a render has begun
    logic                shown_ok = 1'b0;    // displayed half holds a full line
    logic                chk_pend = 1'b0;
    scroll_pkg::hcnt_t   chk_h;
    scroll_pkg::scroll_t ren_h [0:2];
    scroll_pkg::scroll_t ren_v [0:2];
    scroll_pkg::scroll_t shown_h [0:2];
    scroll_pkg::scroll_t shown_v [0:2];
    scroll_pkg::vcnt_t   ren_line, shown_line;

    // expected pixel, straight from the tilemap and ROM models
    function automatic scroll_pkg::pxl_t model_pixel(int lay, int h);
        logic [15:0] x, y;
        int          sh;
        logic [11:0] taddr;
        logic [15:0] td;
        logic [19:0] raddr;
        logic [31:0] word;
        x = 16'(h) + shown_h[lay];
        y = shown_v[lay] + 16'(shown_line);
        sh = 3 + lay;
        taddr = {2'(lay), 4'((y >> sh) & 16'hf), 6'((x >> sh) & 16'h3f)};
        td = scroll_tb.tmap[taddr];
        raddr = {2'(lay), td[10:0], 5'(y % (16'd1 << sh)), 2'((x % (16'd1 << sh)) / 8)};
        word = scroll_tb.rom[raddr];
        return {td[15:11], 4'((word >> (4 * (x % 8))) & 32'hf)};
    endfunction

    task automatic check_px(string name, scroll_pkg::pxl_t got, scroll_pkg::pxl_t exp);
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if ((rst && rst_q) || (!rst && !started)) begin
            check_px("scr1_pxl", scr1_pxl, scroll_pkg::PXL_BLANK);
            check_px("scr2_pxl", scr2_pxl, scroll_pkg::PXL_BLANK);
            check_px("scr3_pxl", scr3_pxl, scroll_pkg::PXL_BLANK);
            if (rom_req !== 1'b0) begin
                err_count++;
                $display("rom_req was raised before the first line started at %0t", $time);
            end
        end
        // outputs settled on the previous pxl_cen edge
        if (chk_pend && !rst) begin
            if (chk_h >= scroll_pkg::hcnt_t'(scroll_pkg::ACTIVE_W)) begin
                check_px("scr1_pxl", scr1_pxl, scroll_pkg::PXL_BLANK);
                check_px("scr2_pxl", scr2_pxl, scroll_pkg::PXL_BLANK);
                check_px("scr3_pxl", scr3_pxl, scroll_pkg::PXL_BLANK);
                blank_count++;
            end else if (shown_ok) begin
                check_px("scr1_pxl", scr1_pxl, model_pixel(0, int'(chk_h)));
                check_px("scr2_pxl", scr2_pxl, model_pixel(1, int'(chk_h)));
                check_px("scr3_pxl", scr3_pxl, model_pixel(2, int'(chk_h)));
                pix_count++;
            end
        end
        chk_pend <= pxl_cen && !rst;
        chk_h    <= hdump;
        rst_q    <= rst;
        if (line_start && !rst) begin
            started    <= 1'b1;
            line_count <= line_count + 1;
            shown_ok   <= render_ok;   // last render moves to display
            render_ok  <= 1'b1;
            shown_h    <= ren_h;
            shown_v    <= ren_v;
            shown_line <= ren_line;
            ren_h[0]   <= scroll_tb.hpos1;
            ren_v[0]   <= scroll_tb.vpos1;
            ren_h[1]   <= scroll_tb.hpos2;
            ren_v[1]   <= scroll_tb.vpos2;
            ren_h[2]   <= scroll_tb.hpos3;
            ren_v[2]   <= scroll_tb.vpos3;
            ren_line   <= scroll_tb.vrender;
        end
    end

    task automatic end_test(string name);
        $display("test %s: %0d pixel checks, %0d blank checks, %0d errors", name,
                 pix_count - base_pix, blank_count - base_blank, err_count - base_err);
        base_pix   = pix_count;
        base_blank = blank_count;
        base_err   = err_count;
    endtask

    task automatic report_totals();
        $display("total: %0d pixel checks, %0d blank checks, %0d errors",
                 pix_count, blank_count, err_count);
    endtask

endmodule

/* test/scroll_tb.sv */
// ####################
// scroll layer testbench
// clock, video timing, tilemap and ROM models
// ####################
`timescale 1ns/100ps

module scroll_tb;

    logic                   clk, rst, pxl_cen, HB;
    scroll_pkg::hcnt_t      hdump;
    scroll_pkg::vcnt_t      vrender, vdump;
    scroll_pkg::scroll_t    hpos1, vpos1, hpos2, vpos2, hpos3, vpos3;
    scroll_pkg::tmap_addr_t tile_addr, addr_q;
    scroll_pkg::tmap_data_t tile_data;
    logic                   rom_req, rom_ack;
    scroll_pkg::rom_addr_t  rom_addr;
    scroll_pkg::rom_data_t  rom_data;
    scroll_pkg::pxl_t       scr1_pxl, scr2_pxl, scr3_pxl;

    scroll_pkg::tmap_data_t tmap [0:4095];
    scroll_pkg::rom_data_t  rom [0:(1 << 20) - 1];

    int   ack_min = 1;
    int   ack_max = 6;
    int   rom_cnt = 0;
    logic rom_busy = 1'b0;
    logic rand_scroll = 1'b0;

    scroll_top u_scroll_top (
        .clk (clk), .rst (rst), .pxl_cen (pxl_cen), .HB (HB),
        .hdump (hdump), .vrender (vrender), .vdump (vdump),
        .hpos1 (hpos1), .vpos1 (vpos1), .hpos2 (hpos2),
        .vpos2 (vpos2), .hpos3 (hpos3), .vpos3 (vpos3),
        .tile_addr (tile_addr), .tile_data (tile_data),
        .rom_req (rom_req), .rom_addr (rom_addr),
        .rom_ack (rom_ack), .rom_data (rom_data),
        .scr1_pxl (scr1_pxl), .scr2_pxl (scr2_pxl), .scr3_pxl (scr3_pxl)
    );

    scroll_checker u_checker (
        .clk (clk), .rst (rst), .pxl_cen (pxl_cen),
        .line_start (u_scroll_top.line_start), .rom_req (rom_req),
        .hdump (hdump), .scr1_pxl (scr1_pxl), .scr2_pxl (scr2_pxl), .scr3_pxl (scr3_pxl)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hdump held two clocks, pxl_cen on the second
    always @(negedge clk) begin
        if (!rst) begin
            if (!pxl_cen) begin
                pxl_cen = 1'b1;
            end else begin
                pxl_cen = 1'b0;
                if (hdump == 9'd511) begin
                    hdump = '0;
                    vdump = vdump + 9'd1;
                end else begin
                    hdump = hdump + 9'd1;
                end
                // late in HB, so the render in progress is already done
                if (rand_scroll && hdump == 9'd480) begin
                    hpos1 = 16'($urandom);
                    vpos1 = 16'($urandom);
                    hpos2 = 16'($urandom);
                    vpos2 = 16'($urandom);
                    hpos3 = 16'($urandom);
                    vpos3 = 16'($urandom);
                end
            end
            HB = hdump >= scroll_pkg::hcnt_t'(scroll_pkg::ACTIVE_W);
            vrender = vdump + 9'd1;
        end
    end

    // tilemap answers one clock after the address
    always @(posedge clk) addr_q <= tile_addr;
    always @(negedge clk) tile_data = tmap[addr_q];

    always @(negedge clk) begin
        if (rst) begin
            rom_ack  = 1'b0;
            rom_busy = 1'b0;
        end else if (rom_req && !rom_ack) begin
            if (!rom_busy) begin
                rom_busy = 1'b1;
                rom_cnt  = ack_min + int'($urandom % (ack_max - ack_min + 1));
            end else if (rom_cnt > 1) begin
                rom_cnt--;
            end else begin
                rom_busy = 1'b0;
                rom_data = rom[rom_addr];
                rom_ack  = 1'b1;
            end
        end else if (!rom_req && rom_ack) begin
            rom_ack = 1'b0;
        end
    end

    task automatic wait_lines(int n);
        int target;
        int cycles;
        target = u_checker.line_count + n;
        cycles = 0;
        while (u_checker.line_count < target && cycles < 2048 * n) begin
            @(negedge clk);
            cycles++;
        end
        if (u_checker.line_count < target) begin
            $display("timeout while waiting for line start");
            $display("Simulation FAILED");
            $finish;
        end
    endtask

    initial begin
        void'($urandom(32'h30c3));
        rst = 1'b1;
        pxl_cen = 1'b0;
        hdump = 9'd256;   // start in HB
        vdump = '0;
        vrender = 9'd1;
        HB = 1'b1;
        {hpos1, vpos1, hpos2, vpos2, hpos3, vpos3} = '0;
        tile_data = '0;
        rom_ack = 1'b0;
        rom_data = '0;
        for (int i = 0; i < 4096; i++) tmap[i] = 16'($urandom);
        for (int i = 0; i < (1 << 20); i++) rom[i] = $urandom;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_lines(1);
        u_checker.end_test("reset");
        wait_lines(4);
        u_checker.end_test("zero_scroll");
        rand_scroll = 1'b1;
        wait_lines(8);
        u_checker.end_test("random_scroll");
        ack_min = 4;
        ack_max = 10;   // heavy back-pressure
        wait_lines(6);
        u_checker.end_test("rom_back_pressure");
        u_checker.report_totals();
        if (u_checker.err_count == 0 && u_checker.pix_count > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
hw/scroll_pkg.sv
hw/scroll_sequencer.sv
hw/tile_fetcher.sv
hw/line_output.sv
hw/scroll_top.sv
test/scroll_sva.sv
test/scroll_checker.sv
test/scroll_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the scroll layer testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module scroll_tb -o scroll_sim || { echo "build failed"; exit 1; }

out="$(./obj_dir/scroll_sim)"
echo "$out"
grep -q "Simulation PASSED" <<< "$out" && exit 0 || exit 1
